// ==== include/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// ==========================================================================
// Fetch front end sizing
// ==========================================================================

// Instruction word and byte address width
`define XLEN_W 32

// Instruction memory depth in 32-bit words
`define ROM_WORDS 2048

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

// Fetch queue capacity, counted in instruction pairs
`define FQ_DEPTH 4

`endif

// ==== logic/isa_pkg.sv ====
`include "fetch_macros.svh"

package isa_pkg;

    // One instruction word
    typedef logic [`XLEN_W-1:0] instr_t;

    // Instruction fields
    // Opcode sits in bits 31..26, function code in bits 5..0
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [4:0] reg_idx_t;

    // Major opcodes of the MIPS-like encoding
    localparam opcode_t op_reg   = 6'b000000;
    localparam opcode_t op_addi  = 6'b001000;
    localparam opcode_t op_load  = 6'b010000;
    localparam opcode_t op_store = 6'b010001;
    localparam opcode_t op_beq   = 6'b000100;
    localparam opcode_t op_bne   = 6'b000101;
    localparam opcode_t op_j     = 6'b000010;

    // Predecode result per slot
    typedef enum logic [2:0] {
        cls_nop,
        cls_alu_reg,
        cls_alu_imm,
        cls_load,
        cls_store,
        cls_branch,
        cls_jump,
        cls_other
    } instr_class_t;

endpackage

// ==== logic/fetch_pkg.sv ====
`include "fetch_macros.svh"

package fetch_pkg;

    // Byte address into instruction space
    typedef logic [`XLEN_W-1:0] addr_t;

    // Word index into the instruction memory
    typedef logic [$clog2(`ROM_WORDS)-1:0] word_idx_t;

    // Queue occupancy or free slots, 0..FQ_DEPTH inclusive
    typedef logic [$clog2(`FQ_DEPTH+1)-1:0] fq_count_t;

    // PC generator FSM
    // st_drain waits out the last read after run drops
    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_drain
    } pcgen_state_t;

endpackage

// ==== logic/inst_rom.sv ====
`include "fetch_macros.svh"

module inst_rom (
    input  logic             clk,
    input  logic             reset,

    // Paired fetch from the PC generator
    input  logic             imem_ren,
    input  fetch_pkg::addr_t imem_addr0,
    input  fetch_pkg::addr_t imem_addr1,

    // Host programming port, one-cycle write strobe
    input  logic             prog_en,
    input  fetch_pkg::addr_t prog_addr,
    input  isa_pkg::instr_t  prog_data,

    // Read response, one clock after imem_ren
    output logic             imem_valid,
    output isa_pkg::instr_t  imem_rdata0,
    output isa_pkg::instr_t  imem_rdata1,
    output fetch_pkg::addr_t imem_pc0,
    output fetch_pkg::addr_t imem_pc1
);
    import fetch_pkg::*;
    import isa_pkg::*;

    localparam int idx_w = $bits(word_idx_t);

    // Storage, loaded by the host only
    instr_t    mem [`ROM_WORDS];

    word_idx_t prog_idx;
    word_idx_t rd_idx0;
    word_idx_t rd_idx1;

    // Word index below memory depth
    function automatic logic in_range(addr_t a);
        return a[`XLEN_W-1:2] < (`XLEN_W-2)'(`ROM_WORDS);
    endfunction

    // Byte address to word index
    assign prog_idx = prog_addr[idx_w+1:2];
    assign rd_idx0  = imem_addr0[idx_w+1:2];
    assign rd_idx1  = imem_addr1[idx_w+1:2];

    // ==========================================================================
    // Programming write
    // ==========================================================================
    always_ff @(posedge clk) begin
        if (prog_en) begin
            mem[prog_idx] <= prog_data;
        end
    end

    // ==========================================================================
    // Registered dual read
    // ==========================================================================

    // Response strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            imem_valid <= 1'b0;
        end else begin
            imem_valid <= imem_ren;
        end
    end

    // Words and PCs captured with the request
    // Anything past the end reads as a NOP
    always_ff @(posedge clk) begin
        if (imem_ren) begin
            imem_rdata0 <= in_range(imem_addr0) ? mem[rd_idx0] : '0;
            imem_rdata1 <= in_range(imem_addr1) ? mem[rd_idx1] : '0;
            imem_pc0    <= imem_addr0;
            imem_pc1    <= imem_addr1;
        end
    end

    // Host loads only while fetch is stopped
    a_prog_vs_fetch: assert property (
        @(posedge clk) disable iff (reset)
        !(prog_en && imem_ren)
    );

    // Host writes stay inside the memory
    a_prog_in_range: assert property (
        @(posedge clk) disable iff (reset)
        prog_en |-> in_range(prog_addr)
    );

endmodule

// ==== logic/fetch_pc_gen.sv ====
`include "fetch_macros.svh"

module fetch_pc_gen (
    input  logic                 clk,
    input  logic                 reset,

    // Host control
    input  logic                 run,
    input  logic                 redirect_en,
    input  fetch_pkg::addr_t     redirect_pc,

    // Queue status
    input  fetch_pkg::fq_count_t free_slots,
    input  logic                 empty,
    input  logic                 out_req,
    input  logic                 out_ack,

    // Read request to the memory
    output logic                 imem_ren,
    output fetch_pkg::addr_t     imem_addr0,
    output fetch_pkg::addr_t     imem_addr1,

    output logic                 flush,
    output logic                 fetch_idle
);
    import fetch_pkg::*;

    pcgen_state_t state;
    pcgen_state_t state_nxt;
    addr_t        pc;
    logic         in_flight;
    logic         credit_ok;

    // ==========================================================================
    // Issue and credit
    // ==========================================================================

    // Room left once the outstanding read lands
    assign credit_ok = free_slots > fq_count_t'(in_flight);

    assign imem_ren   = (state == st_run) && run && credit_ok;
    assign imem_addr0 = pc;
    assign imem_addr1 = pc + addr_t'(4);

    // Quiet front end, nothing held or mid-handshake
    assign fetch_idle = (state == st_idle) && empty && !out_req && !out_ack;

    // Restart pulse, queue cleared on the same edge
    assign flush = redirect_en && fetch_idle;

    // ==========================================================================
    // FSM
    // ==========================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (run) begin
                    state_nxt = st_run;
                end
            end
            st_run: begin
                if (!run) begin
                    state_nxt = st_drain;
                end
            end
            st_drain: begin
                // Last response still to land
                if (!in_flight) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= st_idle;
            pc        <= `RESET_PC;
            in_flight <= 1'b0;
        end else begin
            state     <= state_nxt;
            // Memory answers one clock later
            in_flight <= imem_ren;
            if (flush) begin
                pc <= redirect_pc;
            end else if (imem_ren) begin
                pc <= pc + addr_t'(8);
            end
        end
    end

    // Host restarts only an idle front end
    a_redirect_idle: assert property (
        @(posedge clk) disable iff (reset)
        redirect_en |-> fetch_idle
    );

endmodule

// ==== logic/predecode.sv ====
module predecode (
    // Memory response
    input  logic                  imem_valid,
    input  isa_pkg::instr_t       imem_rdata0,
    input  isa_pkg::instr_t       imem_rdata1,
    input  fetch_pkg::addr_t      imem_pc0,
    input  fetch_pkg::addr_t      imem_pc1,

    // Classified pair toward the queue
    output logic                  pd_push,
    output fetch_pkg::addr_t      pd_pc0,
    output fetch_pkg::addr_t      pd_pc1,
    output isa_pkg::instr_t       pd_instr0,
    output isa_pkg::instr_t       pd_instr1,
    output isa_pkg::instr_class_t pd_class0,
    output isa_pkg::instr_class_t pd_class1,
    output logic                  pd_valid1
);
    import isa_pkg::*;

    // Opcode decode, all-zero register form is the NOP
    function automatic instr_class_t classify(instr_t w);
        opcode_t      op;
        reg_idx_t     rs;
        reg_idx_t     rt;
        reg_idx_t     rd;
        logic [4:0]   shamt;
        funct_t       fn;
        instr_class_t cls;
        op    = w[31:26];
        rs    = w[25:21];
        rt    = w[20:16];
        rd    = w[15:11];
        shamt = w[10:6];
        fn    = w[5:0];
        case (op)
            op_reg: begin
                if (rs == '0 && rt == '0 && rd == '0 && shamt == '0 && fn == '0) begin
                    cls = cls_nop;
                end else begin
                    cls = cls_alu_reg;
                end
            end
            op_addi:  cls = cls_alu_imm;
            op_load:  cls = cls_load;
            op_store: cls = cls_store;
            op_beq,
            op_bne:   cls = cls_branch;
            op_j:     cls = cls_jump;
            default:  cls = cls_other;
        endcase
        return cls;
    endfunction

    // Pair passes straight through
    assign pd_push   = imem_valid;
    assign pd_pc0    = imem_pc0;
    assign pd_pc1    = imem_pc1;
    assign pd_instr0 = imem_rdata0;
    assign pd_instr1 = imem_rdata1;

    assign pd_class0 = classify(imem_rdata0);
    assign pd_class1 = classify(imem_rdata1);

    // Slot 1 dead behind a taken-or-not control transfer
    assign pd_valid1 = !(pd_class0 == cls_branch || pd_class0 == cls_jump);

endmodule

// ==== logic/fetch_queue.sv ====
`include "fetch_macros.svh"

module fetch_queue (
    input  logic                  clk,
    input  logic                  reset,

    // Push side from predecode
    input  logic                  pd_push,
    input  fetch_pkg::addr_t      pd_pc0,
    input  fetch_pkg::addr_t      pd_pc1,
    input  isa_pkg::instr_t       pd_instr0,
    input  isa_pkg::instr_t       pd_instr1,
    input  isa_pkg::instr_class_t pd_class0,
    input  isa_pkg::instr_class_t pd_class1,
    input  logic                  pd_valid1,

    input  logic                  flush,
    input  logic                  out_ack,

    // Status toward the PC generator
    output fetch_pkg::fq_count_t  free_slots,
    output logic                  empty,

    // Four-phase output to decode
    output logic                  out_req,
    output fetch_pkg::addr_t      out_pc0,
    output isa_pkg::instr_t       out_instr0,
    output isa_pkg::instr_class_t out_class0,
    output fetch_pkg::addr_t      out_pc1,
    output isa_pkg::instr_t       out_instr1,
    output isa_pkg::instr_class_t out_class1,
    output logic                  out_valid1
);
    import fetch_pkg::*;
    import isa_pkg::*;

    localparam int ptr_w = $clog2(`FQ_DEPTH);
    typedef logic [ptr_w-1:0] ptr_t;

    // Pair storage
    addr_t        pc0_q    [`FQ_DEPTH];
    addr_t        pc1_q    [`FQ_DEPTH];
    instr_t       instr0_q [`FQ_DEPTH];
    instr_t       instr1_q [`FQ_DEPTH];
    instr_class_t class0_q [`FQ_DEPTH];
    instr_class_t class1_q [`FQ_DEPTH];
    logic         valid1_q [`FQ_DEPTH];

    ptr_t      wr_ptr;
    ptr_t      rd_ptr;
    fq_count_t count;
    logic      pop;
    logic      full;

    // Circular increment
    function automatic ptr_t ptr_inc(ptr_t p);
        return (p == ptr_t'(`FQ_DEPTH-1)) ? '0 : p + 1'b1;
    endfunction

    assign pop        = out_req && out_ack;
    assign full       = (count == fq_count_t'(`FQ_DEPTH));
    assign empty      = (count == '0);
    assign free_slots = fq_count_t'(`FQ_DEPTH) - count;

    // Head pair, steady while out_req is up
    assign out_pc0    = pc0_q[rd_ptr];
    assign out_pc1    = pc1_q[rd_ptr];
    assign out_instr0 = instr0_q[rd_ptr];
    assign out_instr1 = instr1_q[rd_ptr];
    assign out_class0 = class0_q[rd_ptr];
    assign out_class1 = class1_q[rd_ptr];
    assign out_valid1 = valid1_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (pd_push) begin
            pc0_q[wr_ptr]    <= pd_pc0;
            pc1_q[wr_ptr]    <= pd_pc1;
            instr0_q[wr_ptr] <= pd_instr0;
            instr1_q[wr_ptr] <= pd_instr1;
            class0_q[wr_ptr] <= pd_class0;
            class1_q[wr_ptr] <= pd_class1;
            valid1_q[wr_ptr] <= pd_valid1;
        end
    end

    // ==========================================================================
    // Pointers and handshake
    // ==========================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            out_req <= 1'b0;
        end else if (flush) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            out_req <= 1'b0;
        end else begin
            if (pd_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({pd_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Phase 3 drops req, next req waits for ack low
            if (pop) begin
                out_req <= 1'b0;
            end else if (!out_req && !out_ack && !empty) begin
                out_req <= 1'b1;
            end
        end
    end

    // Credit rule upstream keeps a slot for every response
    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset)
        pd_push |-> !full
    );

    // Phase 1 holds req and the head pair until the consumer answers
    a_req_held: assert property (
        @(posedge clk) disable iff (reset)
        (out_req && !out_ack) |=> out_req && $stable(out_pc0)
                                  && $stable(out_instr0) && $stable(out_instr1)
    );

endmodule

// ==== logic/fetch_top.sv ====
module fetch_top (
    input  logic                  clk,
    input  logic                  reset,

    // Host programming
    input  logic                  prog_en,
    input  fetch_pkg::addr_t      prog_addr,
    input  isa_pkg::instr_t       prog_data,

    // Host control
    input  logic                  run,
    input  logic                  redirect_en,
    input  fetch_pkg::addr_t      redirect_pc,

    // Decode side
    input  logic                  out_ack,
    output logic                  out_req,
    output fetch_pkg::addr_t      out_pc0,
    output isa_pkg::instr_t       out_instr0,
    output isa_pkg::instr_class_t out_class0,
    output fetch_pkg::addr_t      out_pc1,
    output isa_pkg::instr_t       out_instr1,
    output isa_pkg::instr_class_t out_class1,
    output logic                  out_valid1,

    output logic                  fetch_idle
);
    import fetch_pkg::*;
    import isa_pkg::*;

    // PC generator to memory
    logic         imem_ren;
    addr_t        imem_addr0;
    addr_t        imem_addr1;

    // Memory to predecode
    logic         imem_valid;
    instr_t       imem_rdata0;
    instr_t       imem_rdata1;
    addr_t        imem_pc0;
    addr_t        imem_pc1;

    // Predecode to queue
    logic         pd_push;
    addr_t        pd_pc0;
    addr_t        pd_pc1;
    instr_t       pd_instr0;
    instr_t       pd_instr1;
    instr_class_t pd_class0;
    instr_class_t pd_class1;
    logic         pd_valid1;

    // Queue back to the PC generator
    fq_count_t    free_slots;
    logic         empty;
    logic         flush;

    // All block ports share the top-level names
    fetch_pc_gen u_pc_gen (.*);

    inst_rom u_rom (.*);

    predecode u_predecode (.*);

    fetch_queue u_queue (.*);

endmodule

// ==== verif/fetch_tb.sv ====
`include "fetch_macros.svh"

module fetch_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import isa_pkg::*;
    import fetch_pkg::*;

    localparam int clk_period    = 40;
    localparam int req_timeout   = 200;
    localparam int drain_timeout = 400;

    // Cycle budgets per test, summed for the watchdog
    localparam int budget_reset    = 16 + 80;
    localparam int budget_seq      = 600;
    localparam int budget_backpres = 12 * (30 + 10) + 100;
    localparam int budget_redirect = 600;
    localparam int budget_range    = 400;
    localparam int budget_cycles   = budget_reset + budget_seq + budget_backpres
                                   + budget_redirect + budget_range;

    logic         clk;
    logic         reset;
    logic         prog_en;
    addr_t        prog_addr;
    instr_t       prog_data;
    logic         run;
    logic         redirect_en;
    addr_t        redirect_pc;
    logic         out_ack;
    logic         out_req;
    addr_t        out_pc0;
    instr_t       out_instr0;
    instr_class_t out_class0;
    addr_t        out_pc1;
    instr_t       out_instr1;
    instr_class_t out_class1;
    logic         out_valid1;
    logic         fetch_idle;

    // Reference copy of every programmed word
    instr_t ref_mem [`ROM_WORDS];

    // Received pairs in arrival order
    addr_t        log_pc0    [$];
    addr_t        log_pc1    [$];
    instr_t       log_instr0 [$];
    instr_t       log_instr1 [$];
    instr_class_t log_class0 [$];
    instr_class_t log_class1 [$];
    logic         log_valid1 [$];

    int errors;
    int checks;
    int seed;
    int seq_first;
    int seq_last;
    int bp_first;

    fetch_top DUT (
        .clk         (clk),
        .reset       (reset),
        .prog_en     (prog_en),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .run         (run),
        .redirect_en (redirect_en),
        .redirect_pc (redirect_pc),
        .out_ack     (out_ack),
        .out_req     (out_req),
        .out_pc0     (out_pc0),
        .out_instr0  (out_instr0),
        .out_class0  (out_class0),
        .out_pc1     (out_pc1),
        .out_instr1  (out_instr1),
        .out_class1  (out_class1),
        .out_valid1  (out_valid1),
        .fetch_idle  (fetch_idle)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ==========================================================================
    // Reference model
    // ==========================================================================

    // Class by opcode, all-zero word is the NOP
    function automatic instr_class_t expected_class(instr_t w);
        instr_class_t cls;
        if (w == '0) begin
            cls = cls_nop;
        end else begin
            case (w[31:26])
                6'b000000: cls = cls_alu_reg;
                6'b001000: cls = cls_alu_imm;
                6'b010000: cls = cls_load;
                6'b010001: cls = cls_store;
                6'b000100,
                6'b000101: cls = cls_branch;
                6'b000010: cls = cls_jump;
                default:   cls = cls_other;
            endcase
        end
        return cls;
    endfunction

    // Beyond the memory depth reads as zero
    function automatic instr_t expected_word(addr_t a);
        if ((a >> 2) < addr_t'(`ROM_WORDS)) begin
            return ref_mem[a[12:2]];
        end
        return '0;
    endfunction

    function automatic instr_t r_form(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, funct_t fn);
        return {6'b000000, rs, rt, rd, 5'b00000, fn};
    endfunction

    function automatic instr_t i_form(opcode_t op, reg_idx_t rs, reg_idx_t rt,
                                      logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Test program, pattern of 7 so branches and jumps hit both slots
    function automatic instr_t program_word(int i);
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        instr_t   w;
        rs = reg_idx_t'(i);
        rt = reg_idx_t'(i + 1);
        rd = reg_idx_t'(i + 2);
        case (i % 7)
            0:       w = '0;
            1:       w = r_form(rs, rt, rd, 6'h20);
            2:       w = i_form(6'b001000, rs, rt, 16'(i * 3));
            3:       w = i_form(6'b010000, rs, rt, 16'(i * 4));
            4:       w = i_form(6'b010001, rs, rt, 16'(i * 4));
            5:       w = i_form((i % 2 == 1) ? 6'b000101 : 6'b000100, rs, rt, 16'hfffe);
            default: w = {6'b000010, 26'(i * 4)};
        endcase
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] observed);
        $display("ERROR at %0t: %s expected %h observed %h", $time, name, expected, observed);
        errors++;
    endtask

    // ==========================================================================
    // Host and consumer models
    // ==========================================================================
    task automatic write_word(input int idx, input instr_t data);
        prog_en   = 1'b1;
        prog_addr = addr_t'(idx * 4);
        prog_data = data;
        ref_mem[idx] = data;
        @(negedge clk);
        prog_en = 1'b0;
    endtask

    task automatic redirect_to(input addr_t target);
        if (fetch_idle !== 1'b1) begin
            $display("ERROR at %0t: redirect needed while fetch was busy", $time);
            errors++;
        end else begin
            redirect_en = 1'b1;
            redirect_pc = target;
            @(negedge clk);
            redirect_en = 1'b0;
        end
    endtask

    // Four-phase handshake, ack raised after the given delay
    task automatic receive_pair(input int delay);
        int waited;
        waited = 0;
        while (out_req !== 1'b1 && waited < req_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (out_req !== 1'b1) begin
            $display("ERROR at %0t: no out_req within %0d cycles", $time, req_timeout);
            errors++;
        end else begin
            log_pc0.push_back(out_pc0);
            log_pc1.push_back(out_pc1);
            log_instr0.push_back(out_instr0);
            log_instr1.push_back(out_instr1);
            log_class0.push_back(out_class0);
            log_class1.push_back(out_class1);
            log_valid1.push_back(out_valid1);
            repeat (delay) @(negedge clk);
            // Head must not move while req is up
            if (out_pc0 !== log_pc0[$]) report_mismatch("out_pc0 held", log_pc0[$], out_pc0);
            out_ack = 1'b1;
            waited = 0;
            while (out_req === 1'b1 && waited < 10) begin
                @(negedge clk);
                waited++;
            end
            if (out_req === 1'b1) begin
                $display("ERROR at %0t: out_req stayed high after out_ack", $time);
                errors++;
            end
            out_ack = 1'b0;
        end
    endtask

    // Drop run, take whatever is left until the front end is quiet
    task automatic stop_and_drain();
        int waited;
        run = 1'b0;
        waited = 0;
        while (fetch_idle !== 1'b1 && waited < drain_timeout) begin
            if (out_req === 1'b1) begin
                receive_pair(0);
            end else begin
                @(negedge clk);
            end
            waited++;
        end
        if (fetch_idle !== 1'b1) begin
            $display("ERROR at %0t: fetch never returned to idle after run dropped", $time);
            errors++;
        end
    endtask

    // Consecutive pairs from start_pc, words against the reference
    task automatic check_sequence(input int first, input int last, input addr_t start_pc);
        addr_t pc;
        for (int i = first; i < last; i++) begin
            pc = start_pc + addr_t'(8 * (i - first));
            checks += 4;
            if (log_pc0[i] !== pc) report_mismatch("out_pc0", pc, log_pc0[i]);
            if (log_pc1[i] !== pc + 4) report_mismatch("out_pc1", pc + 4, log_pc1[i]);
            if (log_instr0[i] !== expected_word(pc))
                report_mismatch("out_instr0", expected_word(pc), log_instr0[i]);
            if (log_instr1[i] !== expected_word(pc + 4))
                report_mismatch("out_instr1", expected_word(pc + 4), log_instr1[i]);
        end
    endtask

    task automatic check_classes(input int first, input int last, input addr_t start_pc);
        addr_t        pc;
        instr_class_t cls0;
        instr_class_t cls1;
        logic         v1;
        for (int i = first; i < last; i++) begin
            pc   = start_pc + addr_t'(8 * (i - first));
            cls0 = expected_class(expected_word(pc));
            cls1 = expected_class(expected_word(pc + 4));
            // Slot 1 dropped behind control flow
            v1   = !(cls0 == cls_branch || cls0 == cls_jump);
            checks += 3;
            if (log_class0[i] !== cls0) report_mismatch("out_class0", 32'(cls0), 32'(log_class0[i]));
            if (log_class1[i] !== cls1) report_mismatch("out_class1", 32'(cls1), 32'(log_class1[i]));
            if (log_valid1[i] !== v1) report_mismatch("out_valid1", 32'(v1), 32'(log_valid1[i]));
        end
    endtask

    // ==========================================================================
    // Directed tests
    // ==========================================================================
    task automatic test_reset_and_load();
        checks += 2;
        if (out_req !== 1'b0) report_mismatch("out_req", 0, 32'(out_req));
        if (fetch_idle !== 1'b1) report_mismatch("fetch_idle", 1, 32'(fetch_idle));
        for (int i = 0; i < 32; i++) begin
            write_word(i, program_word(i));
        end
    endtask

    task automatic test_sequential();
        seq_first = log_pc0.size();
        run = 1'b1;
        // At most four more pairs in flight, so words stay inside the program
        repeat (12) receive_pair(0);
        stop_and_drain();
        seq_last = log_pc0.size();
        check_sequence(seq_first, seq_last, `RESET_PC);
    endtask

    task automatic test_predecode();
        check_classes(seq_first, seq_last, `RESET_PC);
    endtask

    task automatic test_backpressure();
        int delay;
        redirect_to(`RESET_PC);
        bp_first = log_pc0.size();
        run = 1'b1;
        for (int k = 0; k < 8; k++) begin
            delay = {$random(seed)} % 31;
            receive_pair(delay);
        end
    endtask

    task automatic test_redirect();
        int first;
        // Leftovers from the back-pressure run continue its sequence
        stop_and_drain();
        check_sequence(bp_first, log_pc0.size(), `RESET_PC);
        redirect_to(32'h44);
        first = log_pc0.size();
        run = 1'b1;
        repeat (3) receive_pair(0);
        stop_and_drain();
        check_sequence(first, log_pc0.size(), 32'h44);
        check_classes(first, log_pc0.size(), 32'h44);
    endtask

    task automatic test_out_of_range();
        int    first;
        addr_t last_pc;
        last_pc = addr_t'((`ROM_WORDS - 1) * 4);
        write_word(`ROM_WORDS - 1, i_form(6'b001000, 5'd3, 5'd4, 16'h1234));
        redirect_to(last_pc);
        first = log_pc0.size();
        run = 1'b1;
        repeat (4) receive_pair(0);
        stop_and_drain();
        check_sequence(first, log_pc0.size(), last_pc);
        check_classes(first, log_pc0.size(), last_pc);
    endtask

    initial begin
        reset       = 1'b1;
        prog_en     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        run         = 1'b0;
        redirect_en = 1'b0;
        redirect_pc = '0;
        out_ack     = 1'b0;
        errors      = 0;
        checks      = 0;
        seed        = 86;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        test_reset_and_load();
        test_sequential();
        test_predecode();
        test_backpressure();
        test_redirect();
        test_out_of_range();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(budget_cycles * clk_period);
        $display("ERROR at %0t: watchdog expired before the tests finished", $time);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
logic/isa_pkg.sv
logic/fetch_pkg.sv
logic/inst_rom.sv
logic/fetch_pc_gen.sv
logic/predecode.sv
logic/fetch_queue.sv
logic/fetch_top.sv
verif/fetch_tb.sv

// ==== Makefile ====
# Verilator build and run for the fetch front end

TOOL     = verilator
FLAGS    = --timing --assert
TOP      = fetch_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
FAIL_MSG = Test FAILED
PASS_MSG = Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
